//--- common/fpdivsqrt_pkg.sv
package fpdivsqrt_pkg;

  // ------------------------------------------------------------
  // Binary16 format
  // ------------------------------------------------------------
  localparam int fp_width = 16;
  localparam int exp_bits = 5;
  localparam int man_bits = 10;
  localparam int exp_bias = 15;
  // All-ones exponent of infinity and NaN
  localparam int exp_max  = 31;

  // One binary16 word, as raw bits or as its fields
  typedef union packed {
    logic [fp_width-1:0] bits;
    struct packed {
      logic                sign;
      logic [exp_bits-1:0] exp;
      logic [man_bits-1:0] man;
    } f;
  } fp16_u;

  // Results of the special-case and overflow rules
  localparam logic [fp_width-1:0] canonical_nan  = 16'h7E00;
  localparam logic [fp_width-1:0] largest_finite = 16'h7BFF;

  // ------------------------------------------------------------
  // Status flags
  // ------------------------------------------------------------
  localparam int status_width = 5;
  localparam int flag_nv = 4;
  localparam int flag_dz = 3;
  localparam int flag_of = 2;
  localparam int flag_uf = 1;
  localparam int flag_nx = 0;

  // Encoding of op_i
  localparam logic op_div  = 1'b1;
  localparam logic op_sqrt = 1'b0;

endpackage

//--- hw/fp_issue_ctrl.sv
module fp_issue_ctrl #(
  parameter int TagWidth = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   in_valid_i,
  input  logic                                   op_i,
  input  logic [fpdivsqrt_pkg::fp_width-1:0]     operand_a_i,
  input  logic [fpdivsqrt_pkg::fp_width-1:0]     operand_b_i,
  input  logic [TagWidth-1:0]                    tag_i,
  input  logic                                   result_taken_i,
  output logic                                   in_ready_o,
  output logic                                   div_start_o,
  output logic                                   sqrt_start_o,
  output logic [10:0]                            sig_a_o,
  output logic [10:0]                            sig_b_o,
  output logic signed [6:0]                      exp_o,
  output logic                                   sign_o,
  output logic                                   special_valid_o,
  output fpdivsqrt_pkg::fp16_u                   special_result_o,
  output logic [fpdivsqrt_pkg::status_width-1:0] special_status_o,
  output logic [TagWidth-1:0]                    tag_o,
  output logic                                   busy_o
);

  typedef enum logic {IDLE, BUSY} state_e;

  state_e               state_q;
  fpdivsqrt_pkg::fp16_u a, b;
  logic                 a_zero, a_inf, a_qnan, a_snan;
  logic                 b_zero, b_inf, b_qnan, b_snan;
  logic                 is_div, accept, special;
  logic signed [6:0]    exp_a, exp_b;
  logic [TagWidth-1:0]  tag_q;

  // Class bits {zero, inf, qnan, snan}; subnormals count as zero
  function automatic logic [3:0] classify(input fpdivsqrt_pkg::fp16_u x);
    logic exp_ones;
    logic man_zero;
    logic quiet;
    exp_ones = x.f.exp == 5'(fpdivsqrt_pkg::exp_max);
    man_zero = x.f.man == '0;
    quiet    = x.f.man[fpdivsqrt_pkg::man_bits-1];
    classify = {x.f.exp == '0, exp_ones & man_zero,
                exp_ones & !man_zero & quiet, exp_ones & !man_zero & !quiet};
  endfunction

  assign a = operand_a_i;
  assign b = operand_b_i;
  assign {a_zero, a_inf, a_qnan, a_snan} = classify(a);
  assign {b_zero, b_inf, b_qnan, b_snan} = classify(b);

  // ------------------------------------------------------------
  // Handshake and dispatch
  // ------------------------------------------------------------
  // No acceptance in a flush cycle
  assign in_ready_o = (state_q == IDLE) && !flush_i;
  assign accept     = in_valid_i && in_ready_o;
  assign is_div     = op_i == fpdivsqrt_pkg::op_div;
  assign busy_o     = state_q == BUSY;

  assign div_start_o     = accept && is_div && !special;
  assign sqrt_start_o    = accept && !is_div && !special;
  assign special_valid_o = accept && special;

  // Core operands with the hidden bit
  assign sig_a_o = {1'b1, a.f.man};
  assign sig_b_o = {1'b1, b.f.man};
  assign sign_o  = a.f.sign ^ b.f.sign;
  assign exp_a   = {2'b00, a.f.exp};
  assign exp_b   = {2'b00, b.f.exp};
  // Biased quotient exponent, or unbiased exponent for sqrt
  assign exp_o   = is_div ? exp_a - exp_b + 7'(fpdivsqrt_pkg::exp_bias)
                          : exp_a - 7'(fpdivsqrt_pkg::exp_bias);

  // ------------------------------------------------------------
  // Special operands
  // ------------------------------------------------------------
  always_comb begin
    special                = 1'b1;
    special_result_o.bits  = fpdivsqrt_pkg::canonical_nan;
    special_status_o       = '0;
    if (a_qnan || a_snan || (is_div && (b_qnan || b_snan))) begin
      // NaN in, quiet NaN out; NV only on signalling
      special_status_o[fpdivsqrt_pkg::flag_nv] = a_snan || (is_div && b_snan);
    end else if (is_div) begin
      if ((a_zero && b_zero) || (a_inf && b_inf)) begin
        special_status_o[fpdivsqrt_pkg::flag_nv] = 1'b1;
      end else if (a_inf || b_zero) begin
        // Signed infinity, DZ only for a finite dividend
        special_result_o.f.sign = sign_o;
        special_result_o.f.exp  = 5'(fpdivsqrt_pkg::exp_max);
        special_result_o.f.man  = '0;
        special_status_o[fpdivsqrt_pkg::flag_dz] = !a_inf;
      end else if (a_zero || b_inf) begin
        special_result_o.bits   = '0;
        special_result_o.f.sign = sign_o;
      end else begin
        special = 1'b0;
      end
    end else begin
      if (a_zero) begin
        // sqrt(-0) keeps its sign
        special_result_o.bits   = '0;
        special_result_o.f.sign = a.f.sign;
      end else if (a.f.sign) begin
        special_status_o[fpdivsqrt_pkg::flag_nv] = 1'b1;
      end else if (a_inf) begin
        special_result_o.bits  = '0;
        special_result_o.f.exp = 5'(fpdivsqrt_pkg::exp_max);
      end else begin
        special = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // State and tag
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (flush_i) begin
      state_q <= IDLE;
    end else if (accept) begin
      state_q <= BUSY;
    end else if (result_taken_i) begin
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q <= tag_i;
    end
  end

  assign tag_o = tag_q;

endmodule

//--- div/fp_div_core.sv
module fp_div_core (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   div_start_i,
  input  logic [10:0]                            sig_a_i,
  input  logic [10:0]                            sig_b_i,
  input  logic signed [6:0]                      exp_i,
  input  logic                                   sign_i,
  output logic                                   done_o,
  output fpdivsqrt_pkg::fp16_u                   result_o,
  output logic [fpdivsqrt_pkg::status_width-1:0] status_o
);

  // Integer bit, 10 fraction bits and one guard bit
  localparam int QuotBits = 12;

  logic                busy_q, done_q;
  logic [3:0]          cnt_q;
  logic [11:0]         rem_q;
  logic [10:0]         divisor_q;
  logic [QuotBits-1:0] quot_q;
  logic signed [6:0]   exp_q;
  logic                sign_q;
  logic                rem_ge;
  logic signed [6:0]   exp_norm;
  logic [9:0]          man_norm;
  logic                dropped;

  // ------------------------------------------------------------
  // Iteration control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (div_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 4'd1;
        // Last quotient bit, result ready next cycle
        if (cnt_q == 4'(QuotBits - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Restoring radix-2 datapath
  // ------------------------------------------------------------
  // Remainder stays below twice the divisor
  assign rem_ge = rem_q >= {1'b0, divisor_q};

  always_ff @(posedge clk_i) begin
    if (div_start_i) begin
      rem_q     <= {1'b0, sig_a_i};
      divisor_q <= sig_b_i;
      quot_q    <= '0;
      exp_q     <= exp_i;
      sign_q    <= sign_i;
    end else if (busy_q) begin
      quot_q <= {quot_q[QuotBits-2:0], rem_ge};
      rem_q  <= (rem_ge ? rem_q - {1'b0, divisor_q} : rem_q) << 1;
    end
  end

  // ------------------------------------------------------------
  // Normalize, truncate and range check
  // ------------------------------------------------------------
  always_comb begin
    // Quotient lies in (0.5, 2); shift at most one place
    if (quot_q[QuotBits-1]) begin
      man_norm = quot_q[10:1];
      dropped  = quot_q[0];
      exp_norm = exp_q;
    end else begin
      man_norm = quot_q[9:0];
      dropped  = 1'b0;
      exp_norm = exp_q - 7'sd1;
    end

    status_o = '0;
    status_o[fpdivsqrt_pkg::flag_nx] = dropped || (rem_q != '0);
    result_o.f.sign = sign_q;
    result_o.f.exp  = exp_norm[4:0];
    result_o.f.man  = man_norm;

    if (exp_norm >= 7'(fpdivsqrt_pkg::exp_max)) begin
      // Toward zero, overflow stops at the largest finite value
      result_o.bits = {sign_q, fpdivsqrt_pkg::largest_finite[14:0]};
      status_o[fpdivsqrt_pkg::flag_of] = 1'b1;
      status_o[fpdivsqrt_pkg::flag_nx] = 1'b1;
    end else if (exp_norm <= 7'sd0) begin
      // No subnormal output, flush to signed zero
      result_o.bits = {sign_q, 15'd0};
      status_o[fpdivsqrt_pkg::flag_uf] = 1'b1;
      status_o[fpdivsqrt_pkg::flag_nx] = 1'b1;
    end
  end

  assign done_o = done_q;

endmodule

//--- sqrt/fp_sqrt_core.sv
module fp_sqrt_core (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   sqrt_start_i,
  input  logic [10:0]                            sig_i,
  input  logic signed [6:0]                      exp_i,
  output logic                                   done_o,
  output fpdivsqrt_pkg::fp16_u                   result_o,
  output logic [fpdivsqrt_pkg::status_width-1:0] status_o
);

  // Hidden bit plus 10 fraction bits of root
  localparam int RootBits = 11;

  logic                busy_q, done_q;
  logic [3:0]          cnt_q;
  logic [21:0]         rad_q;
  logic [RootBits-1:0] root_q;
  logic [13:0]         rem_q;
  logic signed [6:0]   exp_q;
  logic [13:0]         rem_sh, trial;
  logic                fits;

  // ------------------------------------------------------------
  // Iteration control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (sqrt_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 4'd1;
        if (cnt_q == 4'(RootBits - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Digit-by-digit datapath
  // ------------------------------------------------------------
  // Bring down two radicand bits, try root*4 + 1
  assign rem_sh = {rem_q[11:0], rad_q[21:20]};
  assign trial  = {1'b0, root_q, 2'b01};
  assign fits   = rem_sh >= trial;

  always_ff @(posedge clk_i) begin
    if (sqrt_start_i) begin
      // Odd exponent: double the significand so the root stays in [1, 2)
      rad_q  <= exp_i[0] ? {sig_i, 11'd0} : {1'b0, sig_i, 10'd0};
      root_q <= '0;
      rem_q  <= '0;
      // Floor of e/2 for both signs
      exp_q  <= exp_i >>> 1;
    end else if (busy_q) begin
      rad_q  <= rad_q << 2;
      rem_q  <= fits ? rem_sh - trial : rem_sh;
      root_q <= {root_q[RootBits-2:0], fits};
    end
  end

  // Result is positive and always normal
  always_comb begin
    result_o.f.sign = 1'b0;
    result_o.f.exp  = 5'(exp_q + 7'(fpdivsqrt_pkg::exp_bias));
    result_o.f.man  = root_q[9:0];
    status_o        = '0;
    status_o[fpdivsqrt_pkg::flag_nx] = rem_q != '0;
  end

  assign done_o = done_q;

endmodule

//--- hw/fp_result_merge.sv
module fp_result_merge #(
  parameter int TagWidth = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   div_done_i,
  input  fpdivsqrt_pkg::fp16_u                   div_result_i,
  input  logic [fpdivsqrt_pkg::status_width-1:0] div_status_i,
  input  logic                                   sqrt_done_i,
  input  fpdivsqrt_pkg::fp16_u                   sqrt_result_i,
  input  logic [fpdivsqrt_pkg::status_width-1:0] sqrt_status_i,
  input  logic                                   special_valid_i,
  input  fpdivsqrt_pkg::fp16_u                   special_result_i,
  input  logic [fpdivsqrt_pkg::status_width-1:0] special_status_i,
  input  logic [TagWidth-1:0]                    tag_i,
  input  logic                                   out_ready_i,
  output logic                                   out_valid_o,
  output logic [fpdivsqrt_pkg::fp_width-1:0]     result_o,
  output logic [fpdivsqrt_pkg::status_width-1:0] status_o,
  output logic [TagWidth-1:0]                    tag_o,
  output logic                                   result_taken_o
);

  logic                                   valid_q, load;
  fpdivsqrt_pkg::fp16_u                   result_q, result_d;
  logic [fpdivsqrt_pkg::status_width-1:0] status_q, status_d;

  // At most one source pulses per operation
  assign load = div_done_i || sqrt_done_i || special_valid_i;

  always_comb begin
    if (div_done_i) begin
      result_d = div_result_i;
      status_d = div_status_i;
    end else if (sqrt_done_i) begin
      result_d = sqrt_result_i;
      status_d = sqrt_status_i;
    end else begin
      result_d = special_result_i;
      status_d = special_status_i;
    end
  end

  // ------------------------------------------------------------
  // Output register, held until taken
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (result_taken_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q <= result_d;
      status_q <= status_d;
    end
  end

  assign out_valid_o    = valid_q;
  assign result_o       = result_q.bits;
  assign status_o       = status_q;
  // Issue side keeps the tag stable until the result is taken
  assign tag_o          = tag_i;
  assign result_taken_o = valid_q && out_ready_i;

endmodule

//--- hw/fpdivsqrt_top.sv
module fpdivsqrt_top #(
  parameter int TagWidth = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  logic                                     in_valid_i,
  output logic                                     in_ready_o,
  input  logic                                     op_i,
  input  logic [fpdivsqrt_pkg::fp_width-1:0]       operand_a_i,
  input  logic [fpdivsqrt_pkg::fp_width-1:0]       operand_b_i,
  input  logic [TagWidth-1:0]                      tag_i,
  output logic                                     out_valid_o,
  input  logic                                     out_ready_i,
  output logic [fpdivsqrt_pkg::fp_width-1:0]       result_o,
  output logic [fpdivsqrt_pkg::status_width-1:0]   status_o,
  output logic [TagWidth-1:0]                      tag_o,
  output logic                                     busy_o
);

  // Issue to cores
  logic                    div_start, sqrt_start;
  logic [10:0]             sig_a, sig_b;
  logic signed [6:0]       exp;
  logic                    sign;
  // Special-case path and captured tag
  logic                    special_valid;
  fpdivsqrt_pkg::fp16_u    special_result;
  logic [fpdivsqrt_pkg::status_width-1:0] special_status;
  logic [TagWidth-1:0]     tag_q;
  logic                    result_taken;
  // Core results
  logic                    div_done, sqrt_done;
  fpdivsqrt_pkg::fp16_u    div_result, sqrt_result;
  logic [fpdivsqrt_pkg::status_width-1:0] div_status, sqrt_status;

  fp_issue_ctrl #(.TagWidth(TagWidth)) i_fp_issue_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .in_valid_i       (in_valid_i),
    .op_i             (op_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .tag_i            (tag_i),
    .result_taken_i   (result_taken),
    .in_ready_o       (in_ready_o),
    .div_start_o      (div_start),
    .sqrt_start_o     (sqrt_start),
    .sig_a_o          (sig_a),
    .sig_b_o          (sig_b),
    .exp_o            (exp),
    .sign_o           (sign),
    .special_valid_o  (special_valid),
    .special_result_o (special_result),
    .special_status_o (special_status),
    .tag_o            (tag_q),
    .busy_o           (busy_o)
  );

  fp_div_core i_fp_div_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .div_start_i (div_start),
    .sig_a_i     (sig_a),
    .sig_b_i     (sig_b),
    .exp_i       (exp),
    .sign_i      (sign),
    .done_o      (div_done),
    .result_o    (div_result),
    .status_o    (div_status)
  );

  // Square root works on operand a only
  fp_sqrt_core i_fp_sqrt_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .sqrt_start_i (sqrt_start),
    .sig_i        (sig_a),
    .exp_i        (exp),
    .done_o       (sqrt_done),
    .result_o     (sqrt_result),
    .status_o     (sqrt_status)
  );

  fp_result_merge #(.TagWidth(TagWidth)) i_fp_result_merge (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .div_done_i       (div_done),
    .div_result_i     (div_result),
    .div_status_i     (div_status),
    .sqrt_done_i      (sqrt_done),
    .sqrt_result_i    (sqrt_result),
    .sqrt_status_i    (sqrt_status),
    .special_valid_i  (special_valid),
    .special_result_i (special_result),
    .special_status_i (special_status),
    .tag_i            (tag_q),
    .out_ready_i      (out_ready_i),
    .out_valid_o      (out_valid_o),
    .result_o         (result_o),
    .status_o         (status_o),
    .tag_o            (tag_o),
    .result_taken_o   (result_taken)
  );

endmodule

//--- testbench/fpdivsqrt_sva.sv
module fpdivsqrt_sva #(
  parameter int TagWidth = 4
) (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   flush_i,
  input logic                                   in_ready_o,
  input logic                                   out_valid_o,
  input logic                                   out_ready_i,
  input logic [fpdivsqrt_pkg::fp_width-1:0]     result_o,
  input logic [fpdivsqrt_pkg::status_width-1:0] status_o,
  input logic [TagWidth-1:0]                    tag_o
);

  // ------------------------------------------------------------
  // Output handshake
  // ------------------------------------------------------------
  // Stalled result keeps valid and all its fields
  property hold_while_stalled;
    @(posedge clk_i) disable iff (!rst_ni)
      (out_valid_o && !out_ready_i && !flush_i) |=>
        (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));
  endproperty

  // One operation in flight, so never ready while a result waits
  property no_accept_while_valid;
    @(posedge clk_i) disable iff (!rst_ni)
      !(out_valid_o && in_ready_o);
  endproperty

  // Flushed result is never presented
  property flush_drops_valid;
    @(posedge clk_i) disable iff (!rst_ni)
      flush_i |=> !out_valid_o;
  endproperty

  assert property (hold_while_stalled)
    else $error("Output changed or dropped while stalled by out_ready_i");
  assert property (no_accept_while_valid)
    else $error("in_ready_o and out_valid_o high in the same cycle");
  assert property (flush_drops_valid)
    else $error("out_valid_o high in the cycle after a flush");

endmodule

bind fpdivsqrt_top fpdivsqrt_sva #(.TagWidth(TagWidth)) i_fpdivsqrt_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .status_o    (status_o),
  .tag_o       (tag_o)
);

//--- testbench/fpdivsqrt_tb.sv
module fpdivsqrt_tb;

  localparam int TagWidth = 4;
  localparam int FpWidth  = fpdivsqrt_pkg::fp_width;
  localparam int StWidth  = fpdivsqrt_pkg::status_width;
  // Watchdog budget per table entry
  localparam int CyclesPerEntry = 40;
  localparam logic Div  = fpdivsqrt_pkg::op_div;
  localparam logic Sqrt = fpdivsqrt_pkg::op_sqrt;

  logic clk_i, rst_ni, flush_i, in_valid_i, in_ready_o, op_i;
  logic out_valid_o, out_ready_i, busy_o;
  logic [FpWidth-1:0]  operand_a_i, operand_b_i, result_o;
  logic [StWidth-1:0]  status_o;
  logic [TagWidth-1:0] tag_i, tag_o;

  // One queue per table column
  string               name_q[$];
  logic                op_q[$], flush_q[$];
  logic [FpWidth-1:0]  a_q[$], b_q[$], res_q[$];
  logic [TagWidth-1:0] tag_q[$];
  logic [StWidth-1:0]  st_q[$];
  // Results seen leaving the DUT
  logic [FpWidth-1:0]  rx_res_q[$];
  logic [StWidth-1:0]  rx_st_q[$];
  logic [TagWidth-1:0] rx_tag_q[$];
  int errors, failed_tests;
  bit table_ready;
  // Keeps out_ready_i low so that a result waits
  bit ready_hold;

  fpdivsqrt_top #(.TagWidth(TagWidth)) i_fpdivsqrt_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic void add_entry(input string name, input logic op,
                                    input logic [FpWidth-1:0] a, input logic [FpWidth-1:0] b,
                                    input logic [TagWidth-1:0] tag,
                                    input logic [FpWidth-1:0] res,
                                    input logic [StWidth-1:0] st, input logic flush);
    name_q.push_back(name);
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    tag_q.push_back(tag);
    res_q.push_back(res);
    st_q.push_back(st);
    flush_q.push_back(flush);
  endfunction

  // ------------------------------------------------------------
  // Columns are name, op, a, b, tag, result, status {nv,dz,of,uf,nx} and flush
  // ------------------------------------------------------------
  function automatic void build_table();
    add_entry("div_6_by_3",       Div,  16'h4600, 16'h4200, 4'h1, 16'h4000, 5'h00, 1'b0);
    add_entry("div_7_by_2",       Div,  16'h4700, 16'h4000, 4'h2, 16'h4300, 5'h00, 1'b0);
    add_entry("div_neg6_by_3",    Div,  16'hC600, 16'h4200, 4'h3, 16'hC000, 5'h00, 1'b0);
    add_entry("div_6_by_neg3",    Div,  16'h4600, 16'hC200, 4'h4, 16'hC000, 5'h00, 1'b0);
    add_entry("sqrt_4",           Sqrt, 16'h4400, 16'h0000, 4'h5, 16'h4000, 5'h00, 1'b0);
    add_entry("sqrt_9",           Sqrt, 16'h4880, 16'h0000, 4'h6, 16'h4200, 5'h00, 1'b0);
    add_entry("sqrt_quarter",     Sqrt, 16'h3400, 16'h0000, 4'h7, 16'h3800, 5'h00, 1'b0);
    // 1/3 and sqrt(2) truncate and raise only NX
    add_entry("div_1_by_3",       Div,  16'h3C00, 16'h4200, 4'h8, 16'h3555, 5'h01, 1'b0);
    add_entry("sqrt_2",           Sqrt, 16'h4000, 16'h0000, 4'h9, 16'h3DA8, 5'h01, 1'b0);
    // NaN operands
    add_entry("div_qnan_by_2",    Div,  16'h7E00, 16'h4000, 4'hA, 16'h7E00, 5'h00, 1'b0);
    add_entry("div_2_by_snan",    Div,  16'h4000, 16'h7D00, 4'hB, 16'h7E00, 5'h10, 1'b0);
    add_entry("sqrt_snan",        Sqrt, 16'h7C01, 16'h0000, 4'hC, 16'h7E00, 5'h10, 1'b0);
    add_entry("sqrt_neg_qnan",    Sqrt, 16'hFE00, 16'h0000, 4'hD, 16'h7E00, 5'h00, 1'b0);
    // Invalid operations
    add_entry("div_0_by_0",       Div,  16'h0000, 16'h0000, 4'hE, 16'h7E00, 5'h10, 1'b0);
    add_entry("div_inf_by_ninf",  Div,  16'h7C00, 16'hFC00, 4'hF, 16'h7E00, 5'h10, 1'b0);
    add_entry("sqrt_neg_1",       Sqrt, 16'hBC00, 16'h0000, 4'h0, 16'h7E00, 5'h10, 1'b0);
    // Infinities and zeros
    add_entry("div_1_by_0",       Div,  16'h3C00, 16'h0000, 4'h1, 16'h7C00, 5'h08, 1'b0);
    add_entry("div_neg1_by_0",    Div,  16'hBC00, 16'h0000, 4'h2, 16'hFC00, 5'h08, 1'b0);
    add_entry("div_inf_by_2",     Div,  16'h7C00, 16'h4000, 4'h3, 16'h7C00, 5'h00, 1'b0);
    add_entry("div_2_by_inf",     Div,  16'h4000, 16'h7C00, 4'h4, 16'h0000, 5'h00, 1'b0);
    add_entry("sqrt_neg_zero",    Sqrt, 16'h8000, 16'h0000, 4'h5, 16'h8000, 5'h00, 1'b0);
    add_entry("sqrt_inf",         Sqrt, 16'h7C00, 16'h0000, 4'h6, 16'h7C00, 5'h00, 1'b0);
    // Subnormals read as signed zero
    add_entry("div_subn_by_2",    Div,  16'h0001, 16'h4000, 4'h7, 16'h0000, 5'h00, 1'b0);
    add_entry("div_2_by_neg_subn", Div, 16'h4000, 16'h8001, 4'h8, 16'hFC00, 5'h08, 1'b0);
    add_entry("sqrt_subn",        Sqrt, 16'h0200, 16'h0000, 4'h9, 16'h0000, 5'h00, 1'b0);
    // Range limits
    add_entry("div_overflow",     Div,  16'h7BFF, 16'h1400, 4'hA, 16'h7BFF, 5'h05, 1'b0);
    add_entry("div_underflow",    Div,  16'h8400, 16'h4000, 4'hB, 16'h8000, 5'h03, 1'b0);
    // Preceded by flushed copies of the same operation
    add_entry("div_after_flush",  Div,  16'h4600, 16'h4200, 4'hC, 16'h4000, 5'h00, 1'b1);
    add_entry("sqrt_after_flush", Sqrt, 16'h4000, 16'h0000, 4'hD, 16'h3DA8, 5'h01, 1'b1);
  endfunction

  // Random downstream stalls on about one cycle in four
  task automatic drive_ready_stalls();
    forever begin
      @(posedge clk_i);
      out_ready_i <= (($urandom % 4) != 0) && !ready_hold;
    end
  endtask

  // Record every output handshake
  always @(negedge clk_i) begin
    if (rst_ni && out_valid_o && out_ready_i) begin
      rx_res_q.push_back(result_o);
      rx_st_q.push_back(status_o);
      rx_tag_q.push_back(tag_o);
    end
  end

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------
  task automatic issue_op(input logic op, input logic [FpWidth-1:0] a,
                          input logic [FpWidth-1:0] b, input logic [TagWidth-1:0] tag);
    @(posedge clk_i);
    in_valid_i  <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    tag_i       <= tag;
    do @(negedge clk_i); while (!in_ready_o);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    @(negedge clk_i);
    assert (busy_o && !in_ready_o)
      else begin
        $display("Busy not raised or input still ready after acceptance");
        errors++;
      end
  endtask

  // One-cycle flush from a rising edge, then the DUT must be idle
  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o)
      else begin
        $display("DUT not idle in the cycle after the flush");
        errors++;
      end
  endtask

  task automatic flush_during_op(input int idx);
    // Flush while the core iterates
    issue_op(op_q[idx], a_q[idx], b_q[idx], ~tag_q[idx]);
    repeat (3) @(posedge clk_i);
    pulse_flush();
    // Flush a finished result that waits for the downstream
    ready_hold = 1'b1;
    issue_op(op_q[idx], a_q[idx], b_q[idx], ~tag_q[idx]);
    do @(negedge clk_i); while (!out_valid_o);
    @(posedge clk_i);
    pulse_flush();
    ready_hold = 1'b0;
    // Longer than either core needs
    repeat (20) @(posedge clk_i);
    assert (rx_res_q.size() == 0)
      else begin
        $display("A result of the flushed operation left the DUT");
        errors++;
      end
  endtask

  task automatic run_entry(input int idx);
    int                  errors_before;
    logic [FpWidth-1:0]  got_res;
    logic [StWidth-1:0]  got_st;
    logic [TagWidth-1:0] got_tag;
    errors_before = errors;
    if (flush_q[idx]) begin
      flush_during_op(idx);
    end
    // One cycle for a repeated result to show up
    @(posedge clk_i);
    assert (rx_res_q.size() == 0)
      else begin
        $display("Extra result left the DUT before test %s", name_q[idx]);
        errors++;
      end
    rx_res_q.delete();
    rx_st_q.delete();
    rx_tag_q.delete();
    issue_op(op_q[idx], a_q[idx], b_q[idx], tag_q[idx]);
    // Wait for the result handshake
    do @(posedge clk_i); while (rx_res_q.size() == 0);
    got_res = rx_res_q.pop_front();
    got_st  = rx_st_q.pop_front();
    got_tag = rx_tag_q.pop_front();
    assert (got_res === res_q[idx])
      else begin
        $display("[ERROR] %s result: expected %h, actual %h", name_q[idx], res_q[idx], got_res);
        errors++;
      end
    assert (got_st === st_q[idx])
      else begin
        $display("[ERROR] %s status: expected %b, actual %b", name_q[idx], st_q[idx], got_st);
        errors++;
      end
    assert (got_tag === tag_q[idx])
      else begin
        $display("[ERROR] %s tag: expected %h, actual %h", name_q[idx], tag_q[idx], got_tag);
        errors++;
      end
    if (errors == errors_before) begin
      $display("PASS  %s", name_q[idx]);
    end else begin
      $display("FAIL  %s", name_q[idx]);
      failed_tests++;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h6eaa_818e));
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    tag_i       = '0;
    out_ready_i = 1'b0;
    ready_hold  = 1'b0;
    errors       = 0;
    failed_tests = 0;
    build_table();
    table_ready = 1'b1;
    fork
      drive_ready_stalls();
    join_none
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o)
      else begin
        $display("DUT not idle and ready after reset");
        errors++;
      end
    for (int i = 0; i < name_q.size(); i++) begin
      run_entry(i);
    end
    repeat (10) @(posedge clk_i);
    assert (rx_res_q.size() == 0)
      else begin
        $display("Extra result left the DUT after the last test");
        errors++;
      end
    $display("Tests: %0d, passed: %0d, failed: %0d, failed checks: %0d",
             name_q.size(), name_q.size() - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (name_q.size() * CyclesPerEntry) @(posedge clk_i);
    $display("Run timed out after %0d cycles before all tests finished",
             name_q.size() * CyclesPerEntry);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- sim.f
common/fpdivsqrt_pkg.sv
hw/fp_issue_ctrl.sv
div/fp_div_core.sv
sqrt/fp_sqrt_core.sv
hw/fp_result_merge.sv
hw/fpdivsqrt_top.sv
testbench/fpdivsqrt_sva.sv
testbench/fpdivsqrt_tb.sv
